/* files.f */
ball_geom_pkg.sv
brick_pkg.sv
ball_direction.sv
brick_probe_ctrl.sv
brick_probe_datapath.sv
ball_logic.sv
tb_clock.sv
tb_ball_logic.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ball_logic
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q '>>> FAIL' $(LOG); then \
		echo "simulation reported failure, see $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q '>>> PASS' $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_ball_logic.sv */
`timescale 1ns/1ps

module tb_ball_logic;

	localparam int num_steps = 150;
	// worst step is 3 probes of up to 9 cycles plus setup
	localparam int step_cycles_max = 40;
	localparam int step_wait_max = 100;
	localparam time timeout_ns = (num_steps * step_cycles_max + 100) * 100;

	logic clk;
	logic resetn;
	logic logic_go;
	ball_geom_pkg::coord_t ball_x;
	ball_geom_pkg::coord_t ball_y;
	ball_geom_pkg::coord_t plat_x;
	logic mem_ack;
	ball_geom_pkg::coord_t brick_x;
	ball_geom_pkg::coord_t brick_y;
	brick_pkg::health_t brick_health;
	logic mem_req;
	ball_geom_pkg::coord_t mem_x;
	ball_geom_pkg::coord_t mem_y;
	logic wr_en;
	ball_geom_pkg::coord_t wr_x;
	ball_geom_pkg::coord_t wr_y;
	brick_pkg::health_t wr_health;
	logic x_dir;
	logic y_dir;
	logic plat_hit;
	logic step_done;

	integer seed = 99518;
	int err_value = 0;
	int err_proto = 0;
	int req_count = 0;

	// reference direction bits
	logic exp_xd = 1'b0;
	logic exp_yd = 1'b0;

	// sparse brick field keyed by {x, y}
	brick_pkg::health_t bricks [logic [19:0]];

	// expected probe addresses and writes of the running step
	ball_geom_pkg::coord_t exp_addr_x [$];
	ball_geom_pkg::coord_t exp_addr_y [$];
	ball_geom_pkg::coord_t exp_wr_x [$];
	ball_geom_pkg::coord_t exp_wr_y [$];
	brick_pkg::health_t exp_wr_h [$];

	tb_clock u_clock (
		.clk    (clk),
		.resetn (resetn)
	);

	ball_logic uut (
		.clk          (clk),
		.resetn       (resetn),
		.logic_go     (logic_go),
		.ball_x       (ball_x),
		.ball_y       (ball_y),
		.plat_x       (plat_x),
		.mem_ack      (mem_ack),
		.brick_x      (brick_x),
		.brick_y      (brick_y),
		.brick_health (brick_health),
		.mem_req      (mem_req),
		.mem_x        (mem_x),
		.mem_y        (mem_y),
		.wr_en        (wr_en),
		.wr_x         (wr_x),
		.wr_y         (wr_y),
		.wr_health    (wr_health),
		.x_dir        (x_dir),
		.y_dir        (y_dir),
		.plat_hit     (plat_hit),
		.step_done    (step_done)
	);

	function automatic int rand_below(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	function automatic logic [19:0] cell_key(input ball_geom_pkg::coord_t x,
			input ball_geom_pkg::coord_t y);
		return {x, y};
	endfunction

	function automatic brick_pkg::health_t health_at(input ball_geom_pkg::coord_t x,
			input ball_geom_pkg::coord_t y);
		if (bricks.exists(cell_key(x, y))) begin
			return bricks[cell_key(x, y)];
		end
		return 2'd0;
	endfunction

	// paddle contact worked out in plain integers
	function automatic logic paddle_model(input int bx, input int by, input int px);
		return (by + 5 == 440) && (bx + 5 > px) && (bx < px + 40);
	endfunction

	// one clock edge plus the drive delay
	task automatic next_tick();
		@(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string name, input int expected, input int actual);
		err_value++;
		$display("ERR %s expected %0d actual %0d at %0t", name, expected, actual, $time);
	endtask

	// one edge of the direction rules with walls before paddle before bricks
	task automatic apply_dir(input logic done, input logic v, input logic h);
		if (ball_x == '0) begin
			exp_xd = 1'b1;
		end else if (ball_x == ball_geom_pkg::field_x_max) begin
			exp_xd = 1'b0;
		end else if (done && h) begin
			exp_xd = ~exp_xd;
		end
		if (ball_y == '0) begin
			exp_yd = 1'b1;
		end else if (ball_y == ball_geom_pkg::field_y_max) begin
			exp_yd = 1'b0;
		end else if (paddle_model(int'(ball_x), int'(ball_y), int'(plat_x))) begin
			exp_yd = 1'b0;
		end else if (done && v) begin
			exp_yd = ~exp_yd;
		end
	endtask

	// random brick in a cell with about half of them empty
	task automatic place_brick(input ball_geom_pkg::coord_t x, input ball_geom_pkg::coord_t y);
		if (rand_below(2) == 0) begin
			bricks[cell_key(x, y)] = 2'd0;
		end else begin
			bricks[cell_key(x, y)] = brick_pkg::health_t'(rand_below(4));
		end
	endtask

	task automatic expect_probe(input ball_geom_pkg::coord_t x, input ball_geom_pkg::coord_t y,
			output logic hit);
		brick_pkg::health_t hv;
		hv = health_at(x, y);
		exp_addr_x.push_back(x);
		exp_addr_y.push_back(y);
		hit = (hv != 2'd0);
		if (hit) begin
			exp_wr_x.push_back(x);
			exp_wr_y.push_back(y);
			exp_wr_h.push_back(hv - 2'd1);
		end
	endtask

	task automatic run_step(input int idx);
		int r;
		int cycles;
		int exp_reqs;
		logic v;
		logic h;
		logic d;
		ball_geom_pkg::coord_t xn;
		ball_geom_pkg::coord_t yn;
		// walls and the paddle row come up often
		r = rand_below(8);
		if (r == 0) begin
			ball_x = '0;
		end else if (r == 1) begin
			ball_x = ball_geom_pkg::field_x_max;
		end else begin
			ball_x = 10'(1 + rand_below(629));
		end
		r = rand_below(8);
		if (r == 0) begin
			ball_y = '0;
		end else if (r == 1) begin
			ball_y = ball_geom_pkg::field_y_max;
		end else if (r < 5) begin
			ball_y = 10'd435;
		end else begin
			ball_y = 10'(1 + rand_below(469));
		end
		plat_x = 10'(int'(ball_x) + 10 - rand_below(60));
		next_tick();
		apply_dir(1'b0, 1'b0, 1'b0);
		if (plat_hit != paddle_model(int'(ball_x), int'(ball_y), int'(plat_x))) begin
			report_mismatch("plat_hit", int'(paddle_model(int'(ball_x), int'(ball_y),
				int'(plat_x))), int'(plat_hit));
		end
		if (x_dir != exp_xd) begin
			report_mismatch("x_dir_settle", int'(exp_xd), int'(x_dir));
		end
		if (y_dir != exp_yd) begin
			report_mismatch("y_dir_settle", int'(exp_yd), int'(y_dir));
		end
		// neighbours one pixel ahead
		xn = exp_xd ? ball_x + 10'd1 : ball_x - 10'd1;
		yn = exp_yd ? ball_y + 10'd1 : ball_y - 10'd1;
		place_brick(ball_x, yn);
		place_brick(xn, ball_y);
		place_brick(xn, yn);
		req_count = 0;
		expect_probe(ball_x, yn, v);
		expect_probe(xn, ball_y, h);
		exp_reqs = 2;
		if (!v && !h) begin
			expect_probe(xn, yn, d);
			exp_reqs = 3;
			if (d) begin
				v = 1'b1;
				h = 1'b1;
			end
		end
		logic_go = 1'b1;
		next_tick();
		logic_go = 1'b0;
		cycles = 0;
		while (!step_done && cycles < step_wait_max) begin
			next_tick();
			cycles++;
		end
		if (!step_done) begin
			err_proto++;
			$display("step %0d never signalled step_done", idx);
			exp_addr_x.delete();
			exp_addr_y.delete();
			exp_wr_x.delete();
			exp_wr_y.delete();
			exp_wr_h.delete();
			return;
		end
		if (req_count != exp_reqs) begin
			report_mismatch("req_count", exp_reqs, req_count);
		end
		if (exp_wr_x.size() != 0) begin
			err_proto++;
			$display("step %0d ended with %0d brick writes missing", idx, exp_wr_x.size());
			exp_wr_x.delete();
			exp_wr_y.delete();
			exp_wr_h.delete();
		end
		if (exp_addr_x.size() != 0) begin
			err_proto++;
			$display("step %0d ended with %0d probes never requested", idx, exp_addr_x.size());
			exp_addr_x.delete();
			exp_addr_y.delete();
		end
		// direction takes the hit flags on the step_done edge
		next_tick();
		apply_dir(1'b1, v, h);
		if (step_done) begin
			err_proto++;
			$display("step %0d held step_done longer than one cycle", idx);
		end
		if (x_dir != exp_xd) begin
			report_mismatch("x_dir_step", int'(exp_xd), int'(x_dir));
		end
		if (y_dir != exp_yd) begin
			report_mismatch("y_dir_step", int'(exp_yd), int'(y_dir));
		end
	endtask

	// brick memory with random ack delays plus handshake and write checks
	initial begin : brick_memory
		int delay;
		int drop;
		logic req_prev;
		mem_ack = 1'b0;
		brick_x = '0;
		brick_y = '0;
		brick_health = 2'd0;
		delay = -1;
		drop = -1;
		req_prev = 1'b0;
		forever begin
			next_tick();
			if (resetn) begin
				if (mem_req && !req_prev) begin
					if (mem_ack) begin
						err_proto++;
						$display("mem_req rose while mem_ack was still high at %0t", $time);
					end
					req_count++;
					if (exp_addr_x.size() == 0) begin
						err_proto++;
						$display("unexpected brick probe at %0t", $time);
					end else begin
						if (mem_x != exp_addr_x[0]) begin
							report_mismatch("mem_x", int'(exp_addr_x[0]), int'(mem_x));
						end
						if (mem_y != exp_addr_y[0]) begin
							report_mismatch("mem_y", int'(exp_addr_y[0]), int'(mem_y));
						end
						void'(exp_addr_x.pop_front());
						void'(exp_addr_y.pop_front());
					end
				end
				if (!mem_req && req_prev && !mem_ack) begin
					err_proto++;
					$display("mem_req dropped before mem_ack was given at %0t", $time);
				end
				req_prev = mem_req;
				if (wr_en) begin
					$display("brick write x=%0d y=%0d health=%0d", wr_x, wr_y, wr_health);
					if (exp_wr_x.size() == 0) begin
						err_proto++;
						$display("brick write that no probe called for at %0t", $time);
					end else begin
						if (wr_x != exp_wr_x[0]) begin
							report_mismatch("wr_x", int'(exp_wr_x[0]), int'(wr_x));
						end
						if (wr_y != exp_wr_y[0]) begin
							report_mismatch("wr_y", int'(exp_wr_y[0]), int'(wr_y));
						end
						if (wr_health != exp_wr_h[0]) begin
							report_mismatch("wr_health", int'(exp_wr_h[0]), int'(wr_health));
						end
						void'(exp_wr_x.pop_front());
						void'(exp_wr_y.pop_front());
						void'(exp_wr_h.pop_front());
					end
					bricks[cell_key(wr_x, wr_y)] = wr_health;
				end
				// answer held as long as ack is up
				if (!mem_ack && mem_req) begin
					if (delay < 0) begin
						delay = rand_below(4);
					end
					if (delay == 0) begin
						mem_ack = 1'b1;
						brick_x = mem_x;
						brick_y = mem_y;
						brick_health = health_at(mem_x, mem_y);
						delay = -1;
					end else begin
						delay--;
					end
				end else if (mem_ack && !mem_req) begin
					if (drop < 0) begin
						drop = rand_below(3);
					end
					if (drop == 0) begin
						mem_ack = 1'b0;
						drop = -1;
					end else begin
						drop--;
					end
				end
			end
		end
	end

	initial begin : watchdog
		#(timeout_ns);
		$display("watchdog expired after %0t, simulation stopped", $time);
		$display(">>> FAIL");
		$finish;
	end

	initial begin : stimulus
		logic_go = 1'b0;
		ball_x = 10'd300;
		ball_y = 10'd200;
		plat_x = 10'd100;
		wait (resetn == 1'b1);
		next_tick();
		// outputs after reset
		if (mem_req !== 1'b0) begin
			report_mismatch("reset_mem_req", 0, int'(mem_req));
		end
		if (wr_en !== 1'b0) begin
			report_mismatch("reset_wr_en", 0, int'(wr_en));
		end
		if (step_done !== 1'b0) begin
			report_mismatch("reset_step_done", 0, int'(step_done));
		end
		if (x_dir !== 1'b0) begin
			report_mismatch("reset_x_dir", 0, int'(x_dir));
		end
		if (y_dir !== 1'b0) begin
			report_mismatch("reset_y_dir", 0, int'(y_dir));
		end
		for (int i = 0; i < num_steps; i++) begin
			run_step(i);
		end
		repeat (4) next_tick();
		$display("value errors: %0d, protocol errors: %0d", err_value, err_proto);
		if (err_value == 0 && err_proto == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* tb_clock.sv */
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic resetn
);

	// 100 ns period
	localparam time half_period = 50;

	initial begin
		clk = 1'b0;
		forever #half_period clk = ~clk;
	end

	// reset held for 5 cycles, released just after an edge
	initial begin
		resetn = 1'b0;
		repeat (5) @(posedge clk);
		#1;
		resetn = 1'b1;
	end

endmodule

/* ball_logic.sv */
`timescale 1ns/1ps

module ball_logic (
	input  logic                  clk,
	input  logic                  resetn,
	input  logic                  logic_go,
	input  ball_geom_pkg::coord_t ball_x,
	input  ball_geom_pkg::coord_t ball_y,
	input  ball_geom_pkg::coord_t plat_x,
	input  logic                  mem_ack,
	input  ball_geom_pkg::coord_t brick_x,
	input  ball_geom_pkg::coord_t brick_y,
	input  brick_pkg::health_t    brick_health,
	output logic                  mem_req,
	output ball_geom_pkg::coord_t mem_x,
	output ball_geom_pkg::coord_t mem_y,
	output logic                  wr_en,
	output ball_geom_pkg::coord_t wr_x,
	output ball_geom_pkg::coord_t wr_y,
	output brick_pkg::health_t    wr_health,
	output logic                  x_dir,
	output logic                  y_dir,
	output logic                  plat_hit,
	output logic                  step_done
);

	// collision result of the current step
	logic vertical_hit;
	logic horizontal_hit;

	// controller phase seen by the datapath
	brick_pkg::probe_kind_t  probe;
	brick_pkg::probe_state_t state;

	ball_direction u_direction (
		.clk            (clk),
		.resetn         (resetn),
		.ball_x         (ball_x),
		.ball_y         (ball_y),
		.plat_x         (plat_x),
		.step_done      (step_done),
		.vertical_hit   (vertical_hit),
		.horizontal_hit (horizontal_hit),
		.x_dir          (x_dir),
		.y_dir          (y_dir),
		.plat_hit       (plat_hit)
	);

	brick_probe_ctrl u_ctrl (
		.clk            (clk),
		.resetn         (resetn),
		.logic_go       (logic_go),
		.mem_ack        (mem_ack),
		.vertical_hit   (vertical_hit),
		.horizontal_hit (horizontal_hit),
		.mem_req        (mem_req),
		.probe          (probe),
		.state          (state),
		.step_done      (step_done)
	);

	brick_probe_datapath u_datapath (
		.clk            (clk),
		.resetn         (resetn),
		.state          (state),
		.probe          (probe),
		.ball_x         (ball_x),
		.ball_y         (ball_y),
		.x_dir          (x_dir),
		.y_dir          (y_dir),
		.brick_x        (brick_x),
		.brick_y        (brick_y),
		.brick_health   (brick_health),
		.mem_x          (mem_x),
		.mem_y          (mem_y),
		.wr_en          (wr_en),
		.wr_x           (wr_x),
		.wr_y           (wr_y),
		.wr_health      (wr_health),
		.vertical_hit   (vertical_hit),
		.horizontal_hit (horizontal_hit)
	);

endmodule

/* brick_probe_datapath.sv */
`timescale 1ns/1ps

module brick_probe_datapath (
	input  logic                    clk,
	input  logic                    resetn,
	input  brick_pkg::probe_state_t state,
	input  brick_pkg::probe_kind_t  probe,
	input  ball_geom_pkg::coord_t   ball_x,
	input  ball_geom_pkg::coord_t   ball_y,
	input  logic                    x_dir,
	input  logic                    y_dir,
	input  ball_geom_pkg::coord_t   brick_x,
	input  ball_geom_pkg::coord_t   brick_y,
	input  brick_pkg::health_t      brick_health,
	output ball_geom_pkg::coord_t   mem_x,
	output ball_geom_pkg::coord_t   mem_y,
	output logic                    wr_en,
	output ball_geom_pkg::coord_t   wr_x,
	output ball_geom_pkg::coord_t   wr_y,
	output brick_pkg::health_t      wr_health,
	output logic                    vertical_hit,
	output logic                    horizontal_hit
);

	// ball position frozen for the whole step
	ball_geom_pkg::coord_t x_cur;
	ball_geom_pkg::coord_t y_cur;
	ball_geom_pkg::coord_t x_next;
	ball_geom_pkg::coord_t y_next;

	// current probe found a brick
	logic probe_hit;
	logic brick_hit;

	logic in_idle;
	logic in_check;

	assign in_idle  = (state == brick_pkg::st_idle);
	assign in_check = (state == brick_pkg::st_check);

	// any nonzero health is a live brick
	assign brick_hit = (brick_health != brick_pkg::health_empty);

	// track the ball while idle, one pixel ahead in each axis
	always_ff @(posedge clk) begin
		if (in_idle) begin
			x_cur  <= ball_x;
			y_cur  <= ball_y;
			x_next <= x_dir ? ball_x + ball_geom_pkg::coord_t'(1)
			                : ball_x - ball_geom_pkg::coord_t'(1);
			y_next <= y_dir ? ball_y + ball_geom_pkg::coord_t'(1)
			                : ball_y - ball_geom_pkg::coord_t'(1);
		end
	end

	// probe address, stable while probe is held
	always_comb begin
		case (probe)
			brick_pkg::probe_vert: begin
				mem_x = x_cur;
				mem_y = y_next;
			end
			brick_pkg::probe_horiz: begin
				mem_x = x_next;
				mem_y = y_cur;
			end
			default: begin
				// diagonal corner
				mem_x = x_next;
				mem_y = y_next;
			end
		endcase
	end

	// hit flags, cleared at the start of each step
	always_ff @(posedge clk) begin
		if (!resetn || in_idle) begin
			vertical_hit   <= 1'b0;
			horizontal_hit <= 1'b0;
			probe_hit      <= 1'b0;
		end else if (in_check) begin
			probe_hit <= brick_hit;
			if (brick_hit) begin
				case (probe)
					brick_pkg::probe_vert: begin
						vertical_hit <= 1'b1;
					end
					brick_pkg::probe_horiz: begin
						horizontal_hit <= 1'b1;
					end
					default: begin
						// corner hit bounces both ways
						vertical_hit   <= 1'b1;
						horizontal_hit <= 1'b1;
					end
				endcase
			end
		end
	end

	// write-back payload from the memory answer
	always_ff @(posedge clk) begin
		if (in_check) begin
			wr_x      <= brick_x;
			wr_y      <= brick_y;
			wr_health <= brick_health - brick_pkg::health_t'(1);
		end
	end

	// single pulse, only for a brick that was there
	assign wr_en = (state == brick_pkg::st_write) && probe_hit;

endmodule

/* brick_probe_ctrl.sv */
`timescale 1ns/1ps

module brick_probe_ctrl (
	input  logic                    clk,
	input  logic                    resetn,
	input  logic                    logic_go,
	input  logic                    mem_ack,
	input  logic                    vertical_hit,
	input  logic                    horizontal_hit,
	output logic                    mem_req,
	output brick_pkg::probe_kind_t  probe,
	output brick_pkg::probe_state_t state,
	output logic                    step_done
);

	brick_pkg::probe_state_t state_next;
	brick_pkg::probe_kind_t  probe_next;

	// next phase and next probe
	always_comb begin
		state_next = state;
		probe_next = probe;
		case (state)
			brick_pkg::st_idle: begin
				// every step starts with the vertical neighbour
				if (logic_go) begin
					state_next = brick_pkg::st_req;
					probe_next = brick_pkg::probe_vert;
				end
			end
			brick_pkg::st_req: begin
				// memory may stall here as long as it likes
				if (mem_ack) begin
					state_next = brick_pkg::st_check;
				end
			end
			brick_pkg::st_check: begin
				// answer taken by the datapath this cycle
				state_next = brick_pkg::st_release;
			end
			brick_pkg::st_release: begin
				// no new req until ack has dropped
				if (!mem_ack) begin
					state_next = brick_pkg::st_write;
				end
			end
			brick_pkg::st_write: begin
				case (probe)
					brick_pkg::probe_vert: begin
						state_next = brick_pkg::st_req;
						probe_next = brick_pkg::probe_horiz;
					end
					brick_pkg::probe_horiz: begin
						// corner only matters if both faces were clear
						if (vertical_hit || horizontal_hit) begin
							state_next = brick_pkg::st_done;
						end else begin
							state_next = brick_pkg::st_req;
							probe_next = brick_pkg::probe_diag;
						end
					end
					default: begin
						state_next = brick_pkg::st_done;
					end
				endcase
			end
			brick_pkg::st_done: begin
				state_next = brick_pkg::st_idle;
			end
			default: begin
				state_next = brick_pkg::st_idle;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!resetn) begin
			state <= brick_pkg::st_idle;
			probe <= brick_pkg::probe_vert;
		end else begin
			state <= state_next;
			probe <= probe_next;
		end
	end

	// req stays up through the sample cycle
	// so the memory keeps its answer on the bus
	assign mem_req = (state == brick_pkg::st_req) || (state == brick_pkg::st_check);

	// one cycle, direction logic acts on it
	assign step_done = (state == brick_pkg::st_done);

endmodule

/* ball_direction.sv */
`timescale 1ns/1ps

module ball_direction (
	input  logic                  clk,
	input  logic                  resetn,
	input  ball_geom_pkg::coord_t ball_x,
	input  ball_geom_pkg::coord_t ball_y,
	input  ball_geom_pkg::coord_t plat_x,
	input  logic                  step_done,
	input  logic                  vertical_hit,
	input  logic                  horizontal_hit,
	output logic                  x_dir,
	output logic                  y_dir,
	output logic                  plat_hit
);

	// one extra bit so edge sums never wrap
	logic [ball_geom_pkg::coord_w:0] ball_x_edge;
	logic [ball_geom_pkg::coord_w:0] ball_y_edge;
	logic [ball_geom_pkg::coord_w:0] plat_x_end;

	logic at_left;
	logic at_right;
	logic at_top;
	logic at_bottom;

	// right and bottom edges of the ball
	assign ball_x_edge = {1'b0, ball_x} + ball_geom_pkg::ball_size;
	assign ball_y_edge = {1'b0, ball_y} + ball_geom_pkg::ball_size;

	// far end of the paddle
	assign plat_x_end = {1'b0, plat_x} + ball_geom_pkg::plat_width;

	// ball bottom resting on the paddle row
	// and overlapping the paddle along x
	always_comb begin
		plat_hit = 1'b0;
		if (ball_y_edge == {1'b0, ball_geom_pkg::plat_y}) begin
			if ((ball_x_edge > {1'b0, plat_x}) && ({1'b0, ball_x} < plat_x_end)) begin
				plat_hit = 1'b1;
			end
		end
	end

	// wall contact
	assign at_left   = (ball_x == '0);
	assign at_right  = (ball_x == ball_geom_pkg::field_x_max);
	assign at_top    = (ball_y == '0);
	assign at_bottom = (ball_y == ball_geom_pkg::field_y_max);

	// horizontal direction, 1 moves right
	always_ff @(posedge clk) begin
		if (!resetn) begin
			x_dir <= 1'b0;
		end else begin
			// walls win over anything the brick step found
			if (at_left) begin
				x_dir <= 1'b1;
			end else if (at_right) begin
				x_dir <= 1'b0;
			end else if (step_done && horizontal_hit) begin
				// side of a brick, bounce back
				x_dir <= ~x_dir;
			end
		end
	end

	// vertical direction, 1 moves down
	always_ff @(posedge clk) begin
		if (!resetn) begin
			y_dir <= 1'b0;
		end else begin
			if (at_top) begin
				y_dir <= 1'b1;
			end else if (at_bottom) begin
				y_dir <= 1'b0;
			end else if (plat_hit) begin
				// paddle always sends the ball up
				y_dir <= 1'b0;
			end else if (step_done && vertical_hit) begin
				// top or bottom face of a brick
				y_dir <= ~y_dir;
			end
		end
	end

endmodule

/* brick_pkg.sv */
// brick memory view and collision step encodings
package brick_pkg;

	// remaining hits of one brick
	typedef logic [1:0] health_t;

	// health of an empty cell, no brick there
	localparam health_t health_empty = 2'd0;

	// which neighbour of the ball is being read
	typedef enum logic [1:0] {
		probe_vert,
		probe_horiz,
		probe_diag
	} probe_kind_t;

	// collision step phases, one req/ack round per probe
	typedef enum logic [3:0] {
		// waiting for logic_go
		st_idle,
		// req high, waiting for ack
		st_req,
		// req low, waiting for ack to drop
		st_release,
		// ack seen, answer sampled here
		st_check,
		// write-back slot for a hit brick
		st_write,
		// end of step, step_done pulse
		st_done
	} probe_state_t;

endpackage

/* ball_geom_pkg.sv */
// screen geometry shared by the ball and paddle logic
package ball_geom_pkg;

	// one screen coordinate
	localparam int coord_w = 10;

	// x or y position on the screen
	typedef logic [coord_w-1:0] coord_t;

	// right wall of the playing field
	localparam coord_t field_x_max = 10'd630;

	// bottom edge of the playing field
	localparam coord_t field_y_max = 10'd470;

	// ball is a square of this edge length
	// position is its top left corner
	localparam coord_t ball_size = 10'd5;

	// paddle row, top edge of the paddle
	localparam coord_t plat_y = 10'd440;

	// paddle length along x
	// paddle position is its left end
	localparam coord_t plat_width = 10'd40;

endpackage
